//--- source/monopix_cfg.svh
`ifndef MONOPIX_CFG_SVH
`define MONOPIX_CFG_SVH

// Timestamp and readout word geometry
`define BCID_WIDTH      6
`define NUM_FLAVORS     4
`define NUM_COLS        4
`define COL_ADDR_WIDTH  2
`define HIT_WORD_WIDTH  8     // Column address above timestamp

`define TEST_PATTERN    8'hA5

// Chain fields from LSB are EnOut, EnHitOr, EnTestPattern, EnFlavor and ColPulseSel
`define CONF_WIDTH      32

// All outputs and flavors on with only column 0 of flavor 0 pulsed
`define CONF_DEFAULT    32'h0001F0FF

`endif

//--- source/monopixPkg.sv
`include "monopix_cfg.svh"

package monopixPkg;

    // Flavor order matches the Read/Freeze/Token bit order
    typedef enum logic [1:0] {
        FlavorPmos,
        FlavorPmosDpw,
        FlavorComp,
        FlavorHv
    } tFlavor;

    typedef enum logic {
        RoIdle,
        RoShift
    } tReadState;

    typedef logic [`BCID_WIDTH-1:0]     tBcid;
    typedef logic [`NUM_COLS-1:0]       tColMask;    // One bit per column
    typedef logic [`HIT_WORD_WIDTH-1:0] tHitWord;

endpackage

//--- source/confReg.sv
`include "monopix_cfg.svh"

module confReg (
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    input  logic                                DefConf,
    input  logic                                ShiftConf,
    input  logic                                LdConf,
    input  logic                                SiConf,
    output logic                                SoConf,
    output logic [`NUM_FLAVORS-1:0]             EnOut,
    output logic [`NUM_FLAVORS-1:0]             EnHitOr,
    output logic [`NUM_FLAVORS-1:0]             EnTestPattern,
    output logic [`NUM_FLAVORS-1:0]             EnFlavor,
    output logic [`NUM_FLAVORS*`NUM_COLS-1:0]   ColPulseSel
);

    logic [`CONF_WIDTH-1:0] confChain;     // Serial shift chain
    logic [`CONF_WIDTH-1:0] confActive;    // Copy driving the fields

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            confChain  <= '0;
            confActive <= `CONF_DEFAULT;
        end else begin
            if (ShiftConf)
                confChain <= {confChain[`CONF_WIDTH-2:0], SiConf};
            // Default level wins over a pending load
            if (DefConf)
                confActive <= `CONF_DEFAULT;
            else if (LdConf)
                confActive <= confChain;
        end
    end

    assign SoConf = confChain[`CONF_WIDTH-1];   // Chain MSB

    assign EnOut         = confActive[`NUM_FLAVORS-1:0];
    assign EnHitOr       = confActive[2*`NUM_FLAVORS-1:`NUM_FLAVORS];
    assign EnTestPattern = confActive[3*`NUM_FLAVORS-1:2*`NUM_FLAVORS];
    assign EnFlavor      = confActive[4*`NUM_FLAVORS-1:3*`NUM_FLAVORS];
    assign ColPulseSel   = confActive[`CONF_WIDTH-1:4*`NUM_FLAVORS];

    aDefaultLoad: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        DefConf |=> confActive == `CONF_DEFAULT
    ) else $error("Configuration not at default after DefConf");

endmodule

//--- source/bcidCounter.sv
`include "monopix_cfg.svh"

module bcidCounter (
    input  logic             ClkBx,
    input  logic             reset_ff,
    input  logic             ResetBcid,
    output monopixPkg::tBcid Bcid
);

    logic                   resetBcidQ;   // ResetBcid one edge late
    logic [`BCID_WIDTH-1:0] bcidBin;

    always_ff @(posedge ClkBx) begin
        if (reset_ff)
            resetBcidQ <= 1'b0;
        else
            resetBcidQ <= ResetBcid;
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff || resetBcidQ)
            bcidBin <= '0;
        else
            bcidBin <= bcidBin + 1'b1;
    end

    // Gray code keeps pixel timestamp latches glitch free
    assign Bcid = bcidBin ^ (bcidBin >> 1);

    aGrayStep: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        !$past(reset_ff) && !$past(resetBcidQ) |-> $countones(Bcid ^ $past(Bcid)) == 1
    ) else $error("BCID Gray step changed more than one bit");

endmodule

//--- source/flavorReadout.sv
`include "monopix_cfg.svh"

module flavorReadout (
    input  logic                 ClkBx,
    input  logic                 reset_ff,
    input  logic                 Pulse,
    input  logic                 Read,
    input  logic                 Freeze,
    input  logic                 EnFlavor,
    input  logic                 EnTestPattern,
    input  monopixPkg::tColMask  ColSel,
    input  monopixPkg::tBcid     Bcid,
    output logic                 TokenRaw,
    output logic                 DataRaw,
    output logic                 HitRaw
);

    monopixPkg::tColMask   inj;          // Injection reaching each column now
    monopixPkg::tColMask   injQ;
    monopixPkg::tColMask   capture;
    monopixPkg::tColMask   clearMask;
    monopixPkg::tColMask   pending;
    monopixPkg::tBcid      stamp [`NUM_COLS];
    logic [`COL_ADDR_WIDTH-1:0] pickCol;
    logic                  pickValid;
    logic                  load;
    logic                  take;
    monopixPkg::tReadState state;
    monopixPkg::tHitWord   shiftReg;
    logic [$clog2(`HIT_WORD_WIDTH):0] bitCnt;

    assign inj    = ColSel & {`NUM_COLS{Pulse & EnFlavor}};
    assign HitRaw = |inj;

    // Only a rising edge on an idle column is captured
    assign capture = inj & ~injQ & ~pending & {`NUM_COLS{~Freeze}};

    // Lowest pending column has priority
    always_comb begin
        pickValid = 1'b0;
        pickCol   = '0;
        for (int c = `NUM_COLS - 1; c >= 0; c--) begin
            if (pending[c]) begin
                pickValid = 1'b1;
                pickCol   = `COL_ADDR_WIDTH'(c);
            end
        end
    end

    assign load = (state == monopixPkg::RoIdle) && Read && (EnTestPattern || pickValid);
    assign take = load && !EnTestPattern;    // Test pattern leaves hits pending

    assign clearMask = take ? monopixPkg::tColMask'(1) << pickCol : '0;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            injQ     <= '0;
            pending  <= '0;
            TokenRaw <= 1'b0;
        end else begin
            injQ     <= inj;
            pending  <= (pending | capture) & ~clearMask;
            TokenRaw <= |pending;
        end
    end

    always_ff @(posedge ClkBx) begin
        for (int c = 0; c < `NUM_COLS; c++) begin
            if (capture[c])
                stamp[c] <= Bcid;
        end
    end

    // Readout FSM sends one bit per edge MSB first
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            state   <= monopixPkg::RoIdle;
            bitCnt  <= '0;
            DataRaw <= 1'b0;
        end else begin
            case (state)
                monopixPkg::RoIdle: begin
                    DataRaw <= 1'b0;
                    bitCnt  <= '0;
                    if (load)
                        state <= monopixPkg::RoShift;
                end
                monopixPkg::RoShift: begin
                    DataRaw <= shiftReg[`HIT_WORD_WIDTH-1];
                    bitCnt  <= bitCnt + 1'b1;
                    if (bitCnt == `HIT_WORD_WIDTH - 1)
                        state <= monopixPkg::RoIdle;   // Last bit going out
                end
            endcase
        end
    end

    always_ff @(posedge ClkBx) begin
        if (load)
            shiftReg <= EnTestPattern ? `TEST_PATTERN : {pickCol, stamp[pickCol]};
        else if (state == monopixPkg::RoShift)
            shiftReg <= shiftReg << 1;
    end

    aBitCount: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        state == monopixPkg::RoShift |-> bitCnt <= `HIT_WORD_WIDTH - 1
    ) else $error("Serializer bit counter overran the word");

endmodule

//--- source/outputStage.sv
`include "monopix_cfg.svh"

module outputStage (
    input  logic                    ClkBx,
    input  logic                    reset_ff,
    input  logic [`NUM_FLAVORS-1:0] TokenRaw,
    input  logic [`NUM_FLAVORS-1:0] DataRaw,
    input  logic [`NUM_FLAVORS-1:0] HitRaw,
    input  logic [`NUM_FLAVORS-1:0] EnOut,
    input  logic [`NUM_FLAVORS-1:0] EnHitOr,
    output logic [`NUM_FLAVORS-1:0] Token,
    output logic [`NUM_FLAVORS-1:0] DataOut,
    output logic [`NUM_FLAVORS-1:0] HitOr
);

    // One register stage per output pad
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Token   <= '0;
            DataOut <= '0;
            HitOr   <= '0;
        end else begin
            Token   <= TokenRaw & EnOut;
            DataOut <= DataRaw & EnOut;     // Same enable as the token pad
            HitOr   <= HitRaw & EnHitOr;
        end
    end

    aDisabledQuiet: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        ((Token | DataOut) & ~$past(EnOut)) == '0
    ) else $error("Disabled flavor drove Token or DataOut");

endmodule

//--- source/monopixCore.sv
`include "monopix_cfg.svh"

module monopixCore (
    input  logic                    ClkBx,
    input  logic                    reset_ff,
    input  logic                    DefConf,
    input  logic                    ShiftConf,
    input  logic                    LdConf,
    input  logic                    SiConf,
    input  logic                    ResetBcid,
    input  logic                    Pulse,
    input  logic [`NUM_FLAVORS-1:0] Read,
    input  logic [`NUM_FLAVORS-1:0] Freeze,
    output logic                    SoConf,
    output logic [`NUM_FLAVORS-1:0] Token,
    output logic [`NUM_FLAVORS-1:0] DataOut,
    output logic [`NUM_FLAVORS-1:0] HitOr
);

    logic [`NUM_FLAVORS-1:0]           enOut;
    logic [`NUM_FLAVORS-1:0]           enHitOr;
    logic [`NUM_FLAVORS-1:0]           enTestPattern;
    logic [`NUM_FLAVORS-1:0]           enFlavor;
    logic [`NUM_FLAVORS*`NUM_COLS-1:0] colPulseSel;
    monopixPkg::tBcid                  bcid;
    logic [`NUM_FLAVORS-1:0]           tokenRaw;
    logic [`NUM_FLAVORS-1:0]           dataRaw;
    logic [`NUM_FLAVORS-1:0]           hitRaw;

    confReg uConfReg (
        .ClkBx         (ClkBx),
        .reset_ff      (reset_ff),
        .DefConf       (DefConf),
        .ShiftConf     (ShiftConf),
        .LdConf        (LdConf),
        .SiConf        (SiConf),
        .SoConf        (SoConf),
        .EnOut         (enOut),
        .EnHitOr       (enHitOr),
        .EnTestPattern (enTestPattern),
        .EnFlavor      (enFlavor),
        .ColPulseSel   (colPulseSel)
    );

    bcidCounter uBcidCounter (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .Bcid      (bcid)
    );

    // One readout per pixel flavor sharing the timestamp
    for (genvar i = 0; i < `NUM_FLAVORS; i++) begin : gFlavor
        localparam monopixPkg::tFlavor FlavorId = monopixPkg::tFlavor'(i);

        flavorReadout uFlavorReadout (
            .ClkBx         (ClkBx),
            .reset_ff      (reset_ff),
            .Pulse         (Pulse),
            .Read          (Read[FlavorId]),
            .Freeze        (Freeze[FlavorId]),
            .EnFlavor      (enFlavor[FlavorId]),
            .EnTestPattern (enTestPattern[FlavorId]),
            .ColSel        (colPulseSel[FlavorId*`NUM_COLS +: `NUM_COLS]),
            .Bcid          (bcid),
            .TokenRaw      (tokenRaw[FlavorId]),
            .DataRaw       (dataRaw[FlavorId]),
            .HitRaw        (hitRaw[FlavorId])
        );
    end

    outputStage uOutputStage (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .TokenRaw (tokenRaw),
        .DataRaw  (dataRaw),
        .HitRaw   (hitRaw),
        .EnOut    (enOut),
        .EnHitOr  (enHitOr),
        .Token    (Token),
        .DataOut  (DataOut),
        .HitOr    (HitOr)
    );

endmodule

//--- tests/tbClockGen.sv
module tbClockGen #(
    parameter int HalfPeriod = 2    // Full period of 4
) (
    output logic ClkBx
);

    initial begin
        ClkBx = 1'b0;
        forever #HalfPeriod ClkBx = ~ClkBx;
    end

endmodule

//--- tests/tbMonopix.sv
`include "monopix_cfg.svh"

module tbMonopix;

    logic       ClkBx;
    logic       reset_ff;
    logic       DefConf;
    logic       ShiftConf;
    logic       LdConf;
    logic       SiConf;
    logic       ResetBcid;
    logic       Pulse;
    logic [3:0] Read;
    logic [3:0] Freeze;
    logic       SoConf;
    logic [3:0] Token;
    logic [3:0] DataOut;
    logic [3:0] HitOr;

    int          errCount = 0;
    int          timeoutCount = 0;
    int          seed;
    logic [31:0] rnd;

    // Reference model state
    logic [31:0] mChain;
    logic [31:0] mActive;
    logic        mRstBcidQ;
    logic [5:0]  mCount;
    logic [3:0]  mInjLast [4];
    logic [3:0]  mPend [4];
    logic [5:0]  mStamp [4][4];
    logic [7:0]  mWord [4];
    int          mLeft [4];      // Bits still to serialize
    logic [3:0]  mTokRaw;
    logic [3:0]  mDataRaw;
    logic [3:0]  expToken;
    logic [3:0]  expData;
    logic [3:0]  expHitOr;

    tbClockGen uClockGen (.ClkBx(ClkBx));

    monopixCore u_dut (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ShiftConf (ShiftConf),
        .LdConf    (LdConf),
        .SiConf    (SiConf),
        .ResetBcid (ResetBcid),
        .Pulse     (Pulse),
        .Read      (Read),
        .Freeze    (Freeze),
        .SoConf    (SoConf),
        .Token     (Token),
        .DataOut   (DataOut),
        .HitOr     (HitOr)
    );

    // Fields from LSB are EnOut, EnHitOr, EnTestPattern, EnFlavor and ColPulseSel
    function automatic logic [31:0] makeConf(input logic [15:0] cols, input logic [3:0] enFl,
                                             input logic [3:0] enTp, input logic [3:0] enHit,
                                             input logic [3:0] enOut);
        return {cols, enFl, enTp, enHit, enOut};
    endfunction

    function automatic logic [5:0] grayOf(input logic [5:0] b);
        logic [5:0] g;
        g[5] = b[5];
        for (int i = 0; i < 5; i++)
            g[i] = b[i] ^ b[i+1];
        return g;
    endfunction

    always @(posedge ClkBx) begin : refModel
        logic [3:0] inj;
        logic [3:0] cap;
        logic [3:0] clr;
        int         pick;
        if (reset_ff) begin
            mChain    <= '0;
            mActive   <= `CONF_DEFAULT;
            mRstBcidQ <= 1'b0;
            mCount    <= '0;
            mTokRaw   <= '0;
            mDataRaw  <= '0;
            expToken  <= '0;
            expData   <= '0;
            expHitOr  <= '0;
            for (int f = 0; f < 4; f++) begin
                mInjLast[f] <= '0;
                mPend[f]    <= '0;
                mLeft[f]    <= 0;
            end
        end else begin
            if (ShiftConf)
                mChain <= {mChain[30:0], SiConf};
            if (DefConf)
                mActive <= `CONF_DEFAULT;
            else if (LdConf)
                mActive <= mChain;
            mRstBcidQ <= ResetBcid;
            mCount    <= mRstBcidQ ? 6'd0 : mCount + 6'd1;
            for (int f = 0; f < 4; f++) begin
                inj = (Pulse && mActive[12+f]) ? mActive[16+4*f +: 4] : 4'b0000;
                cap = Freeze[f] ? 4'b0000 : inj & ~mInjLast[f] & ~mPend[f];
                clr = 4'b0000;
                pick = -1;
                for (int c = 3; c >= 0; c--)
                    if (mPend[f][c])
                        pick = c;           // Lowest pending wins
                if (mLeft[f] > 0) begin
                    mDataRaw[f] <= mWord[f][mLeft[f]-1];
                    mLeft[f]    <= mLeft[f] - 1;
                end else begin
                    mDataRaw[f] <= 1'b0;
                    if (Read[f] && mActive[8+f]) begin
                        mWord[f] <= `TEST_PATTERN;
                        mLeft[f] <= 8;
                    end else if (Read[f] && pick >= 0) begin
                        mWord[f] <= {pick[1:0], mStamp[f][pick]};
                        mLeft[f] <= 8;
                        clr[pick] = 1'b1;
                    end
                end
                for (int c = 0; c < 4; c++)
                    if (cap[c])
                        mStamp[f][c] <= grayOf(mCount);
                mInjLast[f] <= inj;
                mPend[f]    <= (mPend[f] | cap) & ~clr;
                mTokRaw[f]  <= |mPend[f];
                expHitOr[f] <= (|inj) && mActive[4+f];
            end
            expToken <= mTokRaw & mActive[3:0];
            expData  <= mDataRaw & mActive[3:0];
        end
    end

    aResetQuiet: assert property (@(posedge ClkBx)
        $fell(reset_ff) |-> (Token | DataOut | HitOr) == 4'b0000 && !SoConf)
        else begin
            errCount++;
            $display("FAIL %0t: outputs not low after reset", $time);
        end

    aTokenData: assert property (@(posedge ClkBx) disable iff (reset_ff)
        Token == expToken && DataOut == expData)
        else begin
            errCount++;
            $display("FAIL %0t: Token %b DataOut %b, expected %b %b", $time,
                     $sampled(Token), $sampled(DataOut), $sampled(expToken), $sampled(expData));
        end

    aHitOr: assert property (@(posedge ClkBx) disable iff (reset_ff) HitOr == expHitOr)
        else begin
            errCount++;
            $display("FAIL %0t: HitOr %b, expected %b", $time, $sampled(HitOr),
                     $sampled(expHitOr));
        end

    aSoConf: assert property (@(posedge ClkBx) disable iff (reset_ff) SoConf == mChain[31])
        else begin
            errCount++;
            $display("FAIL %0t: SoConf %b, expected %b", $time, $sampled(SoConf),
                     $sampled(mChain[31]));
        end

    task automatic shiftWord(input logic [31:0] word);
        for (int i = 31; i >= 0; i--) begin
            @(posedge ClkBx);
            ShiftConf <= 1'b1;
            SiConf    <= word[i];   // MSB first
        end
        @(posedge ClkBx);
        ShiftConf <= 1'b0;
        SiConf    <= 1'b0;
    endtask

    task automatic loadWord(input logic [31:0] word);
        shiftWord(word);
        LdConf <= 1'b1;
        @(posedge ClkBx);
        LdConf <= 1'b0;
    endtask

    task automatic pulseOnce();
        @(posedge ClkBx);
        Pulse <= 1'b1;
        @(posedge ClkBx);
        Pulse <= 1'b0;
    endtask

    task automatic readOut(input int f);
        @(posedge ClkBx);
        Read[f] <= 1'b1;
        @(posedge ClkBx);
        Read[f] <= 1'b0;
        repeat (11) @(posedge ClkBx);     // Word plus output latency
    endtask

    task automatic waitToken(input int f, input logic level);
        int n;
        n = 0;
        while (Token[f] !== level && n < 20) begin
            @(posedge ClkBx);
            n++;
        end
        if (Token[f] !== level) begin
            timeoutCount++;
            $display("Timeout at %0t: Token[%0d] never went to %0b", $time, f, level);
        end
    endtask

    initial begin
        seed      = 32'hc052;
        reset_ff  = 1'b1;
        DefConf   = 1'b0;
        ShiftConf = 1'b0;
        LdConf    = 1'b0;
        SiConf    = 1'b0;
        ResetBcid = 1'b0;
        Pulse     = 1'b0;
        Read      = 4'b0000;
        Freeze    = 4'b0000;
        repeat (8) @(posedge ClkBx);
        reset_ff <= 1'b0;
        repeat (2) @(posedge ClkBx);

        // Default config pulses flavor 0 column 0
        pulseOnce();
        waitToken(0, 1'b1);
        readOut(0);
        waitToken(0, 1'b0);

        // Random bits come back out of SoConf while the real word goes in
        rnd = $random(seed);
        shiftWord(rnd);
        loadWord(makeConf(16'h0200, 4'hF, 4'h0, 4'hF, 4'hF));
        pulseOnce();
        waitToken(2, 1'b1);
        readOut(2);
        waitToken(2, 1'b0);
        @(posedge ClkBx);
        DefConf <= 1'b1;
        LdConf  <= 1'b1;
        @(posedge ClkBx);
        DefConf <= 1'b0;
        LdConf  <= 1'b0;
        pulseOnce();
        waitToken(0, 1'b1);
        readOut(0);
        waitToken(0, 1'b0);

        // Two hits on flavor 1 with column 3 repulsed while pending
        @(posedge ClkBx);
        ResetBcid <= 1'b1;
        @(posedge ClkBx);
        ResetBcid <= 1'b0;
        loadWord(makeConf(16'h0080, 4'hF, 4'h0, 4'hF, 4'hF));
        pulseOnce();
        repeat (3) @(posedge ClkBx);
        loadWord(makeConf(16'h00A0, 4'hF, 4'h0, 4'hF, 4'hF));
        pulseOnce();
        waitToken(1, 1'b1);
        readOut(1);
        readOut(1);
        waitToken(1, 1'b0);

        // Frozen flavor 1 and disabled flavor 3
        loadWord(makeConf(16'h4010, 4'b0111, 4'h0, 4'hF, 4'hF));
        @(posedge ClkBx);
        Freeze[1] <= 1'b1;
        pulseOnce();
        @(posedge ClkBx);
        Freeze[1] <= 1'b0;
        repeat (6) @(posedge ClkBx);

        // Test pattern keeps the hit pending
        loadWord(makeConf(16'h0004, 4'hF, 4'b0001, 4'hF, 4'hF));
        pulseOnce();
        waitToken(0, 1'b1);
        readOut(0);
        loadWord(makeConf(16'h0004, 4'hF, 4'h0, 4'hF, 4'hF));
        readOut(0);
        waitToken(0, 1'b0);

        // Flavor 3 outputs gated off while flavor 0 keeps running
        loadWord(makeConf(16'h8001, 4'hF, 4'h0, 4'b0111, 4'b0111));
        pulseOnce();
        repeat (4) @(posedge ClkBx);
        readOut(3);
        readOut(0);
        waitToken(0, 1'b0);
        repeat (4) @(posedge ClkBx);

        $display("Assertion failures: %0d, wait timeouts: %0d", errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/monopixPkg.sv
source/confReg.sv
source/bcidCounter.sv
source/flavorReadout.sv
source/outputStage.sv
source/monopixCore.sv
tests/tbClockGen.sv
tests/tbMonopix.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f all.f --top-module tbMonopix -o simTb &&
./obj_dir/simTb | tee /dev/stderr | grep -qx "No errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
